//--- Makefile
# Verilator simulation of the CSR unit

VERILATOR ?= verilator
TOP       ?= csr_unit_tb
FILELIST  ?= csr_unit.f
LOG       ?= sim.log

.PHONY: run clean

# Build, run into the log, then require the pass line
run:
	$(VERILATOR) --binary --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- csr_unit.f
rtl/csr_pkg.sv
rtl/csr_cmd_front.sv
rtl/mstatus_reg.sv
rtl/csr_file.sv
rtl/csr_resp_back.sv
rtl/csr_unit_top.sv
tb/csr_unit_tb.sv

//--- rtl/csr_cmd_front.sv
`timescale 1ns/10ps

module csr_cmd_front (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req,
    input  csr_pkg::csr_cmd_t cmd,
    output logic              issue,
    output csr_pkg::csr_cmd_t issued_cmd
);

    typedef enum logic [1:0] {
        FRONT_IDLE,
        FRONT_ISSUE,
        FRONT_WAIT_DROP
    } front_state_e;

    front_state_e state;
    front_state_e state_nxt;

    // One issue per req rising phase
    always_comb begin
        state_nxt = state;
        case (state)
            FRONT_IDLE: begin
                if (req) begin
                    state_nxt = FRONT_ISSUE;
                end
            end
            FRONT_ISSUE: begin
                state_nxt = FRONT_WAIT_DROP;
            end
            FRONT_WAIT_DROP: begin
                // req held high is back-pressure, stay here
                if (!req) begin
                    state_nxt = FRONT_IDLE;
                end
            end
            default: begin
                state_nxt = FRONT_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= FRONT_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Command is latched on the edge req is first seen
    always_ff @(posedge clk) begin
        if (state == FRONT_IDLE && req) begin
            issued_cmd <= cmd;
        end
    end

    assign issue = (state == FRONT_ISSUE);

endmodule

//--- rtl/csr_file.sv
`timescale 1ns/10ps

module csr_file (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               issue,
    input  csr_pkg::csr_cmd_t  issued_cmd,
    output logic               done,
    output csr_pkg::csr_resp_t result
);

    logic [31:0] mie_q;
    logic [31:0] mip_q;
    logic [31:0] mscratch_q;
    logic [31:0] mepc_q;
    logic [31:0] mcause_q;
    logic [31:0] mtval_q;

    logic [31:0]    mstatus;
    csr_pkg::priv_e priv;

    logic [31:0] old_val;
    logic        addr_valid;
    logic [31:0] new_val;
    logic        is_csr_op;
    logic        wants_write;
    logic        illegal;
    logic        do_write;
    logic        is_trap;
    logic        is_mret;
    logic [31:0] trap_cause;

    csr_pkg::csr_resp_t resp_nxt;

    // Read mux, unknown addresses read zero
    always_comb begin
        addr_valid = 1'b1;
        case (issued_cmd.addr)
            csr_pkg::MVENDORID_ADDR:  old_val = csr_pkg::MVENDORID_VAL;
            csr_pkg::MARCHID_ADDR:    old_val = csr_pkg::MARCHID_VAL;
            csr_pkg::MIMPID_ADDR:     old_val = csr_pkg::MIMPID_VAL;
            csr_pkg::MHARTID_ADDR:    old_val = csr_pkg::MHARTID_VAL;
            csr_pkg::MSTATUS_ADDR:    old_val = mstatus;
            csr_pkg::MISA_ADDR:       old_val = csr_pkg::MISA_VAL;
            csr_pkg::MIE_ADDR:        old_val = mie_q;
            csr_pkg::MTVEC_ADDR:      old_val = csr_pkg::TRAP_VECTOR;
            csr_pkg::MCOUNTEREN_ADDR: old_val = csr_pkg::MCOUNTEREN_VAL;
            csr_pkg::MSCRATCH_ADDR:   old_val = mscratch_q;
            csr_pkg::MEPC_ADDR:       old_val = mepc_q;
            csr_pkg::MCAUSE_ADDR:     old_val = mcause_q;
            csr_pkg::MTVAL_ADDR:      old_val = mtval_q;
            csr_pkg::MIP_ADDR:        old_val = mip_q;
            default: begin
                old_val    = 32'b0;
                addr_valid = 1'b0;
            end
        endcase
    end

    // Set/clear arithmetic
    always_comb begin
        case (issued_cmd.op)
            csr_pkg::CSR_RS: new_val = old_val | issued_cmd.wdata;
            csr_pkg::CSR_RC: new_val = old_val & ~issued_cmd.wdata;
            default:         new_val = issued_cmd.wdata;
        endcase
    end

    assign is_csr_op = (issued_cmd.op == csr_pkg::CSR_RW) ||
                       (issued_cmd.op == csr_pkg::CSR_RS) ||
                       (issued_cmd.op == csr_pkg::CSR_RC);
    assign is_trap   = (issued_cmd.op == csr_pkg::CSR_TRAP);
    assign is_mret   = (issued_cmd.op == csr_pkg::CSR_MRET);

    // rs/rc with a zero operand only reads
    assign wants_write = (issued_cmd.op == csr_pkg::CSR_RW) ||
                         (is_csr_op && (issued_cmd.wdata != 32'b0));

    // Top two address bits set means read-only space
    assign illegal  = is_csr_op &&
                      (!addr_valid || (wants_write && (issued_cmd.addr[11:10] == 2'b11)));
    assign do_write = issue && is_csr_op && wants_write && !illegal;

    // ecall code depends on the privilege before the trap
    always_comb begin
        if (issued_cmd.cause == csr_pkg::EXC_MISALIGNED) begin
            trap_cause = csr_pkg::MCAUSE_MISALIGNED;
        end else if (priv == csr_pkg::PRIV_M) begin
            trap_cause = csr_pkg::MCAUSE_ECALL_M;
        end else begin
            trap_cause = csr_pkg::MCAUSE_ECALL_U;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mie_q      <= 32'b0;
            mip_q      <= 32'b0;
            mscratch_q <= 32'b0;
            mepc_q     <= csr_pkg::MEPC_RESET;
            mcause_q   <= 32'b0;
            mtval_q    <= 32'b0;
        end else if (issue && is_trap) begin
            mepc_q   <= {issued_cmd.pc[31:2], 2'b00};
            mtval_q  <= issued_cmd.tval;
            mcause_q <= trap_cause;
        end else if (do_write) begin
            // Hardwired and information registers fall through
            case (issued_cmd.addr)
                csr_pkg::MIE_ADDR:      mie_q      <= new_val & csr_pkg::MIE_MASK;
                csr_pkg::MIP_ADDR:      mip_q      <= new_val & csr_pkg::MIP_MASK;
                csr_pkg::MSCRATCH_ADDR: mscratch_q <= new_val;
                csr_pkg::MEPC_ADDR:     mepc_q     <= {new_val[31:2], 2'b00};
                csr_pkg::MCAUSE_ADDR:   mcause_q   <= new_val;
                csr_pkg::MTVAL_ADDR:    mtval_q    <= new_val;
                default: ;
            endcase
        end
    end

    mstatus_reg u_mstatus_reg (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en      (do_write && (issued_cmd.addr == csr_pkg::MSTATUS_ADDR)),
        .wr_data    (new_val),
        .trap_enter (issue && is_trap),
        .mret       (issue && is_mret),
        .mstatus    (mstatus),
        .priv       (priv)
    );

    always_comb begin
        resp_nxt.rdata    = is_csr_op ? old_val : 32'b0;
        resp_nxt.illegal  = illegal;
        if (is_trap) begin
            resp_nxt.redirect = csr_pkg::TRAP_VECTOR;
        end else if (is_mret) begin
            resp_nxt.redirect = mepc_q;
        end else begin
            resp_nxt.redirect = 32'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done <= 1'b0;
        end else begin
            done <= issue;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            result <= resp_nxt;
        end
    end

endmodule

//--- rtl/csr_pkg.sv
package csr_pkg;

    // Machine information registers
    localparam logic [11:0] MVENDORID_ADDR  = 12'hf11;
    localparam logic [11:0] MARCHID_ADDR    = 12'hf12;
    localparam logic [11:0] MIMPID_ADDR     = 12'hf13;
    localparam logic [11:0] MHARTID_ADDR    = 12'hf14;

    // Machine trap setup
    localparam logic [11:0] MSTATUS_ADDR    = 12'h300;
    localparam logic [11:0] MISA_ADDR       = 12'h301;
    localparam logic [11:0] MIE_ADDR        = 12'h304;
    localparam logic [11:0] MTVEC_ADDR      = 12'h305;
    localparam logic [11:0] MCOUNTEREN_ADDR = 12'h306;

    // Machine trap handling
    localparam logic [11:0] MSCRATCH_ADDR   = 12'h340;
    localparam logic [11:0] MEPC_ADDR       = 12'h341;
    localparam logic [11:0] MCAUSE_ADDR     = 12'h342;
    localparam logic [11:0] MTVAL_ADDR      = 12'h343;
    localparam logic [11:0] MIP_ADDR        = 12'h344;

    // Fixed read values
    localparam logic [31:0] MVENDORID_VAL   = 32'h0000_0000;
    localparam logic [31:0] MARCHID_VAL     = 32'h0000_0000;
    localparam logic [31:0] MIMPID_VAL      = 32'h0000_0000;
    localparam logic [31:0] MHARTID_VAL     = 32'h0000_0000;
    localparam logic [31:0] MCOUNTEREN_VAL  = 32'h0000_0000;
    // RV32I plus the U extension
    localparam logic [31:0] MISA_VAL        = 32'h4010_0100;
    // Direct mode, also where every trap lands
    localparam logic [31:0] TRAP_VECTOR     = 32'h0000_0100;
    // Matches the core's pc reset value
    localparam logic [31:0] MEPC_RESET      = 32'h0001_0000;

    // Writable bits of mie and mip
    localparam logic [31:0] MIE_MASK        = 32'h0000_0888;
    localparam logic [31:0] MIP_MASK        = 32'h0000_0008;

    // mcause codes
    localparam logic [31:0] MCAUSE_MISALIGNED = 32'd0;
    localparam logic [31:0] MCAUSE_ECALL_U    = 32'd8;
    localparam logic [31:0] MCAUSE_ECALL_M    = 32'd11;

    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_M = 2'b11
    } priv_e;

    typedef enum logic [2:0] {
        CSR_RW   = 3'd0,
        CSR_RS   = 3'd1,
        CSR_RC   = 3'd2,
        CSR_TRAP = 3'd3,
        CSR_MRET = 3'd4
    } csr_op_e;

    typedef enum logic {
        EXC_MISALIGNED = 1'b0,
        EXC_ECALL      = 1'b1
    } exc_cause_e;

    // One command from the core, 112 bits
    typedef struct packed {
        csr_op_e     op;
        logic [11:0] addr;
        logic [31:0] wdata;
        exc_cause_e  cause;
        logic [31:0] pc;
        logic [31:0] tval;
    } csr_cmd_t;

    // Response back to the core, 65 bits
    typedef struct packed {
        logic [31:0] rdata;
        logic [31:0] redirect;
        logic        illegal;
    } csr_resp_t;

endpackage

//--- rtl/csr_resp_back.sv
`timescale 1ns/10ps

module csr_resp_back (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               req,
    input  logic               done,
    input  csr_pkg::csr_resp_t result,
    output logic               ack,
    output csr_pkg::csr_resp_t resp
);

    typedef enum logic {
        BACK_IDLE,
        BACK_ACKED
    } back_state_e;

    back_state_e state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= BACK_IDLE;
            resp  <= '0;
        end else begin
            case (state)
                BACK_IDLE: begin
                    if (done) begin
                        state <= BACK_ACKED;
                        resp  <= result;
                    end
                end
                BACK_ACKED: begin
                    // Return half, wait for the core to drop req
                    if (!req) begin
                        state <= BACK_IDLE;
                    end
                end
                default: begin
                    state <= BACK_IDLE;
                end
            endcase
        end
    end

    assign ack = (state == BACK_ACKED);

endmodule

//--- rtl/csr_unit_top.sv
`timescale 1ns/10ps

module csr_unit_top (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               req,
    input  csr_pkg::csr_cmd_t  cmd,
    output logic               ack,
    output csr_pkg::csr_resp_t resp
);

    logic               issue;
    csr_pkg::csr_cmd_t  issued_cmd;
    logic               done;
    csr_pkg::csr_resp_t result;

    csr_cmd_front u_front (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .cmd        (cmd),
        .issue      (issue),
        .issued_cmd (issued_cmd)
    );

    csr_file u_csr_file (
        .clk        (clk),
        .rst_n      (rst_n),
        .issue      (issue),
        .issued_cmd (issued_cmd),
        .done       (done),
        .result     (result)
    );

    csr_resp_back u_back (
        .clk    (clk),
        .rst_n  (rst_n),
        .req    (req),
        .done   (done),
        .result (result),
        .ack    (ack),
        .resp   (resp)
    );

endmodule

//--- rtl/mstatus_reg.sv
`timescale 1ns/10ps

module mstatus_reg (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           wr_en,
    input  logic [31:0]    wr_data,
    input  logic           trap_enter,
    input  logic           mret,
    output logic [31:0]    mstatus,
    output csr_pkg::priv_e priv
);

    logic           mie_bit;
    logic           mpie_bit;
    csr_pkg::priv_e mpp;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mie_bit  <= 1'b0;
            mpie_bit <= 1'b0;
            mpp      <= csr_pkg::PRIV_U;
            priv     <= csr_pkg::PRIV_M;
        end else if (trap_enter) begin
            // Stack interrupt enable and privilege, enter M
            mpie_bit <= mie_bit;
            mie_bit  <= 1'b0;
            mpp      <= priv;
            priv     <= csr_pkg::PRIV_M;
        end else if (mret) begin
            mie_bit  <= mpie_bit;
            mpie_bit <= 1'b1;
            priv     <= mpp;
            mpp      <= csr_pkg::PRIV_U;
        end else if (wr_en) begin
            mie_bit  <= wr_data[3];
            mpie_bit <= wr_data[7];
            // No S mode, anything but M falls back to U
            mpp      <= (wr_data[12:11] == 2'b11) ? csr_pkg::PRIV_M : csr_pkg::PRIV_U;
        end
    end

    // Unimplemented fields read as zero
    assign mstatus = {
        19'b0,
        mpp,
        3'b0,
        mpie_bit,
        3'b0,
        mie_bit,
        3'b0
    };

endmodule

//--- tb/csr_unit_tb.sv
`timescale 1ns/10ps

module csr_unit_tb;

    localparam int WAIT_LIMIT = 40;

    logic               clk = 1'b0;
    logic               rst_n;
    logic               req;
    csr_pkg::csr_cmd_t  cmd;
    logic               ack;
    csr_pkg::csr_resp_t resp;

    logic [31:0] seed = 32'h4c37;
    logic [31:0] scratch_model;

    // Stimulus table held as three parallel queues
    string              names[$];
    csr_pkg::csr_cmd_t  cmds[$];
    csr_pkg::csr_resp_t exps[$];

    csr_unit_top dut (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .cmd   (cmd),
        .ack   (ack),
        .resp  (resp)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic stop_with_failure();
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_resp(input string name, input csr_pkg::csr_resp_t exp,
                              input csr_pkg::csr_resp_t act);
        if (act !== exp) begin
            $display("error %s: expected rdata %h redirect %h illegal %b, actual %h %h %b",
                     name, exp.rdata, exp.redirect, exp.illegal,
                     act.rdata, act.redirect, act.illegal);
            stop_with_failure();
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        if (act !== exp) begin
            $display("error %s: expected %h, actual %h", name, exp, act);
            stop_with_failure();
        end
    endtask

    function automatic csr_pkg::csr_resp_t make_resp(input logic [31:0] rdata,
                                                     input logic [31:0] redirect,
                                                     input logic illegal);
        csr_pkg::csr_resp_t r;
        r.rdata    = rdata;
        r.redirect = redirect;
        r.illegal  = illegal;
        return r;
    endfunction

    task automatic add_csr(input string name, input csr_pkg::csr_op_e op,
                           input logic [11:0] addr, input logic [31:0] wdata,
                           input logic [31:0] exp_rdata, input logic exp_illegal);
        csr_pkg::csr_cmd_t c;
        c       = '0;
        c.op    = op;
        c.addr  = addr;
        c.wdata = wdata;
        names.push_back(name);
        cmds.push_back(c);
        exps.push_back(make_resp(exp_rdata, 32'h0, exp_illegal));
    endtask

    // A plain read is rs with a zero operand
    task automatic add_read(input string name, input logic [11:0] addr,
                            input logic [31:0] exp_rdata);
        add_csr(name, csr_pkg::CSR_RS, addr, 32'h0, exp_rdata, 1'b0);
    endtask

    // Traps and mret
    task automatic add_flow(input string name, input csr_pkg::csr_op_e op,
                            input csr_pkg::exc_cause_e cause, input logic [31:0] pc,
                            input logic [31:0] tval, input logic [31:0] exp_redirect);
        csr_pkg::csr_cmd_t c;
        c       = '0;
        c.op    = op;
        c.cause = cause;
        c.pc    = pc;
        c.tval  = tval;
        names.push_back(name);
        cmds.push_back(c);
        exps.push_back(make_resp(32'h0, exp_redirect, 1'b0));
    endtask

    // Full four-phase handshake with req optionally held after ack
    task automatic do_cmd(input csr_pkg::csr_cmd_t c, input int hold,
                          output csr_pkg::csr_resp_t r, output int latency);
        int waited;
        cmd    = c;
        req    = 1'b1;
        waited = 0;
        // Step just past E0 where req is first sampled
        @(negedge clk);
        while (ack !== 1'b1) begin
            if (waited == WAIT_LIMIT) begin
                $display("timeout waiting for ack to rise");
                stop_with_failure();
            end
            @(negedge clk);
            waited++;
        end
        latency = waited;
        r       = resp;
        repeat (hold) begin
            @(negedge clk);
            if (ack !== 1'b1) begin
                $display("ack dropped while req was still held high");
                stop_with_failure();
            end
            check_resp("resp held under back-pressure", r, resp);
        end
        req    = 1'b0;
        waited = 0;
        while (ack !== 1'b0) begin
            if (waited == WAIT_LIMIT) begin
                $display("timeout waiting for ack to fall");
                stop_with_failure();
            end
            @(negedge clk);
            waited++;
        end
    endtask

    task automatic build_table();
        add_read("mvendorid", csr_pkg::MVENDORID_ADDR, csr_pkg::MVENDORID_VAL);
        add_read("marchid", csr_pkg::MARCHID_ADDR, csr_pkg::MARCHID_VAL);
        add_read("mimpid", csr_pkg::MIMPID_ADDR, csr_pkg::MIMPID_VAL);
        add_read("mhartid", csr_pkg::MHARTID_ADDR, csr_pkg::MHARTID_VAL);
        add_read("misa", csr_pkg::MISA_ADDR, csr_pkg::MISA_VAL);
        add_read("mtvec", csr_pkg::MTVEC_ADDR, csr_pkg::TRAP_VECTOR);
        add_read("mcounteren", csr_pkg::MCOUNTEREN_ADDR, 32'h0);
        add_csr("mtvec write", csr_pkg::CSR_RW, csr_pkg::MTVEC_ADDR, 32'h2000,
                csr_pkg::TRAP_VECTOR, 1'b0);
        add_read("mtvec after write", csr_pkg::MTVEC_ADDR, csr_pkg::TRAP_VECTOR);
        // Masked and aligned registers
        add_csr("mie all ones", csr_pkg::CSR_RW, csr_pkg::MIE_ADDR, 32'hffff_ffff, 32'h0, 1'b0);
        add_read("mie masked", csr_pkg::MIE_ADDR, csr_pkg::MIE_MASK);
        add_csr("mip all ones", csr_pkg::CSR_RW, csr_pkg::MIP_ADDR, 32'hffff_ffff, 32'h0, 1'b0);
        add_read("mip masked", csr_pkg::MIP_ADDR, csr_pkg::MIP_MASK);
        add_csr("mepc write 7", csr_pkg::CSR_RW, csr_pkg::MEPC_ADDR, 32'h7,
                csr_pkg::MEPC_RESET, 1'b0);
        add_read("mepc aligned", csr_pkg::MEPC_ADDR, 32'h4);
        add_csr("unknown address", csr_pkg::CSR_RS, 12'h7c0, 32'h0, 32'h0, 1'b1);
        add_csr("mhartid write", csr_pkg::CSR_RW, csr_pkg::MHARTID_ADDR, 32'h5a5a,
                csr_pkg::MHARTID_VAL, 1'b1);
        add_read("mhartid unchanged", csr_pkg::MHARTID_ADDR, csr_pkg::MHARTID_VAL);
        // MPP U with MPIE set so mret returns to U
        add_csr("mepc for mret", csr_pkg::CSR_RW, csr_pkg::MEPC_ADDR, 32'h2000, 32'h4, 1'b0);
        add_csr("mstatus mpie", csr_pkg::CSR_RW, csr_pkg::MSTATUS_ADDR, 32'h80, 32'h0, 1'b0);
        add_flow("mret", csr_pkg::CSR_MRET, csr_pkg::EXC_ECALL, 32'h0, 32'h0, 32'h2000);
        add_read("mstatus after mret", csr_pkg::MSTATUS_ADDR, 32'h88);
        add_flow("ecall from U", csr_pkg::CSR_TRAP, csr_pkg::EXC_ECALL, 32'h3006,
                 32'hdead_beef, csr_pkg::TRAP_VECTOR);
        add_read("mcause ecall U", csr_pkg::MCAUSE_ADDR, csr_pkg::MCAUSE_ECALL_U);
        add_read("mepc after ecall", csr_pkg::MEPC_ADDR, 32'h3004);
        add_read("mtval after ecall", csr_pkg::MTVAL_ADDR, 32'hdead_beef);
        add_read("mstatus after ecall", csr_pkg::MSTATUS_ADDR, 32'h80);
        add_flow("ecall from M", csr_pkg::CSR_TRAP, csr_pkg::EXC_ECALL, 32'h4000, 32'h0,
                 csr_pkg::TRAP_VECTOR);
        add_read("mcause ecall M", csr_pkg::MCAUSE_ADDR, csr_pkg::MCAUSE_ECALL_M);
        add_flow("misaligned", csr_pkg::CSR_TRAP, csr_pkg::EXC_MISALIGNED, 32'h5002,
                 32'h5002, csr_pkg::TRAP_VECTOR);
        add_read("mcause misaligned", csr_pkg::MCAUSE_ADDR, csr_pkg::MCAUSE_MISALIGNED);
        add_read("mtval misaligned", csr_pkg::MTVAL_ADDR, 32'h5002);
    endtask

    initial begin
        csr_pkg::csr_cmd_t  c;
        csr_pkg::csr_resp_t r;
        int                 latency;
        req   = 1'b0;
        cmd   = '0;
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        if (ack !== 1'b0) begin
            $display("ack is not low after reset");
            stop_with_failure();
        end

        build_table();
        for (int i = 0; i < names.size(); i++) begin
            do_cmd(cmds[i], 0, r, latency);
            check_resp(names[i], exps[i], r);
        end

        // Random read-modify-write against the mscratch model
        scratch_model = 32'h0;
        for (int n = 0; n < 24; n++) begin
            c       = '0;
            c.addr  = csr_pkg::MSCRATCH_ADDR;
            c.wdata = next_rand();
            case (next_rand() % 32'd3)
                32'd0:   c.op = csr_pkg::CSR_RW;
                32'd1:   c.op = csr_pkg::CSR_RS;
                default: c.op = csr_pkg::CSR_RC;
            endcase
            do_cmd(c, 0, r, latency);
            check_resp($sformatf("mscratch random %0d", n),
                       make_resp(scratch_model, 32'h0, 1'b0), r);
            case (c.op)
                csr_pkg::CSR_RW: scratch_model = c.wdata;
                csr_pkg::CSR_RS: scratch_model = scratch_model | c.wdata;
                default:         scratch_model = scratch_model & ~c.wdata;
            endcase
        end

        // Set held for 10 cycles with ack due two edges after E0
        c       = '0;
        c.op    = csr_pkg::CSR_RS;
        c.addr  = csr_pkg::MSCRATCH_ADDR;
        c.wdata = 32'h8000_0011;
        do_cmd(c, 10, r, latency);
        check_resp("mscratch set held", make_resp(scratch_model, 32'h0, 1'b0), r);
        check_word("ack latency", 32'd2, latency);
        scratch_model = scratch_model | c.wdata;
        c.wdata       = 32'h0;
        do_cmd(c, 0, r, latency);
        check_word("mscratch after held set", scratch_model, r.rdata);

        // A held trap must stack MIE into MPIE only once
        c       = '0;
        c.op    = csr_pkg::CSR_RS;
        c.addr  = csr_pkg::MSTATUS_ADDR;
        c.wdata = 32'h8;
        do_cmd(c, 0, r, latency);
        check_resp("mstatus set mie", make_resp(32'h1800, 32'h0, 1'b0), r);
        c.op    = csr_pkg::CSR_TRAP;
        c.cause = csr_pkg::EXC_MISALIGNED;
        do_cmd(c, 10, r, latency);
        check_resp("trap held", make_resp(32'h0, csr_pkg::TRAP_VECTOR, 1'b0), r);
        c.op    = csr_pkg::CSR_RS;
        c.wdata = 32'h0;
        do_cmd(c, 0, r, latency);
        check_word("mstatus after held trap", 32'h1880, r.rdata);

        $display("Result: PASSED");
        $finish;
    end

endmodule
